// ==== hw/capture_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shared widths and vector types of the capture path
////////////////////////////////////////////////////////////////////////////

package capture_pkg;

	// channel side
	localparam int NUM_CH         = 8;   // detector channels
	localparam int CH_W           = 3;   // bits of a channel number
	localparam int SAMPLE_W       = 16;  // one detector sample

	// dram side
	localparam int LINE_W         = 256;                // one avalon beat
	localparam int WORDS_PER_LINE = LINE_W / SAMPLE_W;  // 16 samples per line
	localparam int ADDR_W         = 25;                 // line address, not byte
	localparam int BURST_W        = 5;                  // avalon burstcount

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [LINE_W-1:0]   line_t;
	typedef logic [CH_W-1:0]     chan_t;
	typedef logic [NUM_CH-1:0]   chan_mask_t;   // bit n belongs to channel n
	typedef logic [ADDR_W-1:0]   dram_addr_t;   // {channel, line counter}
	typedef logic [BURST_W-1:0]  burst_cnt_t;

endpackage

`default_nettype wire

// ==== hw/lane_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_packer import capture_pkg::*; #(
	parameter int BURST_BEATS = 2       // lines per dram burst
) (
	input  logic    avalon_clk,
	input  logic    rst_n,
	// sample stream from the front end
	input  logic    in_valid,
	input  sample_t in_data,
	output logic    in_ready,
	// burst buffer towards the arbiter
	output logic    line_ready,
	output line_t   line_data,
	input  logic    rd_req              // one pulse per line read out
);

	localparam int PTR_W  = (BURST_BEATS > 1) ? $clog2(BURST_BEATS) : 1;
	localparam int WORD_W = $clog2(WORDS_PER_LINE);

	logic [WORD_W-1:0] word_cnt;        // next sample slot in line_reg
	logic [PTR_W-1:0]  wr_ptr;          // next line slot to fill
	logic [PTR_W-1:0]  rd_ptr;          // line shown on line_data
	logic              full;            // whole burst held
	logic              take;            // sample accepted this cycle
	logic              last_word;
	line_t             line_reg;        // line being assembled
	line_t             line_next;
	line_t             line_mem [BURST_BEATS];

	assign take       = in_valid && in_ready;
	assign last_word  = (word_cnt == WORD_W'(WORDS_PER_LINE - 1));
	assign in_ready   = !full;          // single buffer, stall while it drains
	assign line_ready = full;
	assign line_data  = line_mem[rd_ptr];   // combinational read port

	// current sample dropped into its slot, lowest word first
	always_comb begin
		line_next = line_reg;
		line_next[word_cnt*SAMPLE_W +: SAMPLE_W] = in_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// fill / drain control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			word_cnt <= '0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			full     <= 1'b0;
		end else begin
			if (take) begin
				word_cnt <= last_word ? '0 : word_cnt + 1'b1;
				if (last_word) begin    // line complete, commit it
					if (wr_ptr == PTR_W'(BURST_BEATS - 1)) begin
						wr_ptr <= '0;
						full   <= 1'b1; // line_ready next cycle
					end else begin
						wr_ptr <= wr_ptr + 1'b1;
					end
				end
			end
			// take and rd_req never coincide, full selects one of them
			if (rd_req) begin
				if (rd_ptr == PTR_W'(BURST_BEATS - 1)) begin
					rd_ptr <= '0;
					full   <= 1'b0;     // buffer free, in_ready back
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
		end
	end

	// line storage
	always_ff @(posedge avalon_clk) begin
		if (take) begin
			line_reg <= line_next;
		end
		if (take && last_word) begin
			line_mem[wr_ptr] <= line_next;
		end
	end

	// arbiter must only read a buffer that it was told is full
	a_rd_only_when_ready: assert property (
		@(posedge avalon_clk) disable iff (!rst_n)
		rd_req |-> line_ready
	) else $error("lane_packer: rd_req without line_ready");

endmodule

`default_nettype wire

// ==== hw/burst_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_arbiter import capture_pkg::*; (
	input  logic                avalon_clk,
	input  logic                rst_n,
	// packer side
	input  chan_mask_t          line_ready,
	input  line_t [NUM_CH-1:0]  line_data,
	output chan_mask_t          rd_req,
	// write controller side
	output logic                grant_valid,
	output chan_t               grant_ch,
	output line_t               sel_line,     // registered line mux
	input  logic                beat_take,
	input  logic                burst_done
);

	chan_t last_ch;     // channel served last, search starts after it
	chan_t pick;        // next ready channel in round-robin order
	logic  found;

	// round-robin search, wraps naturally since NUM_CH is 2**CH_W
	always_comb begin
		pick  = last_ch;
		found = 1'b0;
		for (int i = 1; i <= NUM_CH; i++) begin
			if (!found && line_ready[chan_t'(last_ch + i)]) begin
				found = 1'b1;
				pick  = chan_t'(last_ch + i);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// grant register, held for one whole burst
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			grant_valid <= 1'b0;
			grant_ch    <= '0;
			last_ch     <= chan_t'(NUM_CH - 1);   // channel 0 first
		end else if (grant_valid) begin
			if (burst_done) begin
				grant_valid <= 1'b0;
				last_ch     <= grant_ch;
			end
		end else if (found) begin
			grant_valid <= 1'b1;
			grant_ch    <= pick;
		end
	end

	// select register, lags the packer read pointer by one cycle
	always_ff @(posedge avalon_clk) begin
		sel_line <= line_data[grant_ch];
	end

	// controller beat pulses go to the granted packer only
	always_comb begin
		rd_req = '0;
		if (grant_valid && beat_take) begin
			rd_req[grant_ch] = 1'b1;
		end
	end

	// granted buffer stays full until its burst has been read out
	a_grant_buffer_held: assert property (
		@(posedge avalon_clk) disable iff (!rst_n)
		grant_valid && !burst_done |-> line_ready[grant_ch]
	) else $error("burst_arbiter: granted buffer lost line_ready");

endmodule

`default_nettype wire

// ==== hw/dram_write_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_write_ctrl import capture_pkg::*; #(
	parameter int BURST_BEATS = 2       // beats per avalon burst
) (
	input  logic       avalon_clk,
	input  logic       rst_n,
	// arbiter side
	input  logic       grant_valid,
	input  chan_t      grant_ch,
	input  line_t      sel_line,
	output logic       beat_take,       // beat accepted, advance the packer
	output logic       burst_done,      // last beat accepted
	// avalon write master
	input  logic       avl_waitrequest_n,
	output logic       avl_write,
	output dram_addr_t avl_address,
	output line_t      avl_writedata,
	output burst_cnt_t avl_burstcount,
	output logic       avl_beginbursttransfer
);

	localparam int BEAT_W = (BURST_BEATS > 1) ? $clog2(BURST_BEATS) : 1;
	localparam int OFFS_W = ADDR_W - CH_W;  // per-channel line offset

	typedef enum logic [1:0] {
		IDLE,
		LOAD,       // select register settles on the next line
		WRITE       // beat on the bus until waitrequest_n
	} wr_state_t;

	wr_state_t         state;
	logic [BEAT_W-1:0] beat_cnt;        // beat within the current burst
	logic              last_beat;
	logic [OFFS_W-1:0] line_cnt [NUM_CH];   // next line offset per channel

	assign last_beat  = (beat_cnt == BEAT_W'(BURST_BEATS - 1));
	assign beat_take  = (state == WRITE) && avl_waitrequest_n;
	assign burst_done = beat_take && last_beat;

	////////////////////////////////////////////////////////////////////////////
	// avalon outputs
	////////////////////////////////////////////////////////////////////////////

	assign avl_write              = (state == WRITE);
	assign avl_beginbursttransfer = (state == WRITE) && (beat_cnt == '0);   // first beat only
	assign avl_burstcount         = burst_cnt_t'(BURST_BEATS);
	// select register is stable through WRITE, the packer only moves on a take
	assign avl_writedata          = sel_line;

	// burst FSM and beat counter
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (grant_valid) begin
						state <= LOAD;
					end
				end
				LOAD: state <= WRITE;
				WRITE: begin
					if (avl_waitrequest_n) begin
						if (last_beat) begin
							state    <= IDLE;
							beat_cnt <= '0;
						end else begin
							state    <= LOAD;
							beat_cnt <= beat_cnt + 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// line counter table, advances one burst per finished grant and wraps
	always_ff @(posedge avalon_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_CH; i++) begin
				line_cnt[i] <= '0;
			end
		end else if (burst_done) begin
			line_cnt[grant_ch] <= line_cnt[grant_ch] + OFFS_W'(BURST_BEATS);
		end
	end

	// burst address, latched once per grant and held for every beat
	always_ff @(posedge avalon_clk) begin
		if (state == IDLE && grant_valid) begin
			avl_address <= {grant_ch, line_cnt[grant_ch]};
		end
	end

	// slave holding a beat must see the same data and address
	a_beat_held: assert property (
		@(posedge avalon_clk) disable iff (!rst_n)
		avl_write && !avl_waitrequest_n |=> $stable(avl_writedata) && $stable(avl_address)
	) else $error("dram_write_ctrl: beat changed under waitrequest");

endmodule

`default_nettype wire

// ==== hw/capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_top import capture_pkg::*; #(
	parameter int BURST_BEATS = 2           // lines per channel burst
) (
	input  logic                  avalon_clk,
	input  logic                  rst_n,
	// detector channels
	input  chan_mask_t            in_valid,
	input  sample_t [NUM_CH-1:0]  in_data,
	output chan_mask_t            in_ready,
	// avalon write port to the dram controller
	input  logic                  avl_waitrequest_n,
	output logic                  avl_write,
	output dram_addr_t            avl_address,
	output line_t                 avl_writedata,
	output burst_cnt_t            avl_burstcount,
	output logic                  avl_beginbursttransfer
);

	////////////////////////////////////////////////////////////////////////////
	// packer to arbiter
	////////////////////////////////////////////////////////////////////////////
	chan_mask_t          line_ready;    // bit per channel, burst held
	line_t [NUM_CH-1:0]  line_data;     // line at each read pointer
	chan_mask_t          rd_req;

	// arbiter to write controller
	logic  grant_valid;
	chan_t grant_ch;
	line_t sel_line;
	logic  beat_take;
	logic  burst_done;

	// one packer per detector channel
	for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_lane
		lane_packer #(
			.BURST_BEATS (BURST_BEATS)
		) u_lane (
			.avalon_clk (avalon_clk),
			.rst_n      (rst_n),
			.in_valid   (in_valid[ch]),
			.in_data    (in_data[ch]),
			.in_ready   (in_ready[ch]),
			.line_ready (line_ready[ch]),
			.line_data  (line_data[ch]),
			.rd_req     (rd_req[ch])
		);
	end

	burst_arbiter u_arb (
		.avalon_clk  (avalon_clk),
		.rst_n       (rst_n),
		.line_ready  (line_ready),
		.line_data   (line_data),
		.rd_req      (rd_req),
		.grant_valid (grant_valid),
		.grant_ch    (grant_ch),
		.sel_line    (sel_line),
		.beat_take   (beat_take),
		.burst_done  (burst_done)
	);

	dram_write_ctrl #(
		.BURST_BEATS (BURST_BEATS)
	) u_wr (
		.avalon_clk             (avalon_clk),
		.rst_n                  (rst_n),
		.grant_valid            (grant_valid),
		.grant_ch               (grant_ch),
		.sel_line               (sel_line),
		.beat_take              (beat_take),
		.burst_done             (burst_done),
		.avl_waitrequest_n      (avl_waitrequest_n),
		.avl_write              (avl_write),
		.avl_address            (avl_address),
		.avl_writedata          (avl_writedata),
		.avl_burstcount         (avl_burstcount),
		.avl_beginbursttransfer (avl_beginbursttransfer)
	);

endmodule

`default_nettype wire

// ==== test/tb_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_capture_top import capture_pkg::*; ();

	localparam int BURST_BEATS    = 2;
	localparam int BURST_SAMPLES  = BURST_BEATS * WORDS_PER_LINE;  // 32 samples per burst
	localparam int OFFS_W         = ADDR_W - CH_W;
	localparam int MAX_SAMPLES    = 512;
	localparam int STREAM_TIMEOUT = 4000;   // cycles
	localparam int DRAIN_TIMEOUT  = 2000;
	localparam logic [31:0] SEED  = 32'h4824b19a;

	logic                 avalon_clk = 1'b0;
	logic                 rst_n;
	chan_mask_t           in_valid;
	sample_t [NUM_CH-1:0] in_data;
	chan_mask_t           in_ready;
	logic                 avl_waitrequest_n;
	logic                 avl_write;
	dram_addr_t           avl_address;
	line_t                avl_writedata;
	burst_cnt_t           avl_burstcount;
	logic                 avl_beginbursttransfer;

	// scoreboard
	sample_t    sent [NUM_CH][MAX_SAMPLES];    // accepted samples per channel, in order
	int         sent_cnt [NUM_CH];
	int         got [NUM_CH];                 // bursts seen per channel
	dram_addr_t last_addr [NUM_CH];
	int         total_bursts;
	int         beat_idx;                     // beat within the burst on the bus
	chan_t      cur_ch;
	dram_addr_t cur_addr;
	logic       held_valid;                   // beat stalled by the slave last edge
	line_t      held_data;
	dram_addr_t held_addr;
	int         errors;
	int         tests_run;
	int         tests_failed;
	int         errors_at_start;
	string      test_name;
	logic [31:0] rng;                         // sample stream
	logic [31:0] wr_rng;                      // slave stalls
	bit         random_wait;

	capture_top #(
		.BURST_BEATS (BURST_BEATS)
	) DUT (
		.avalon_clk             (avalon_clk),
		.rst_n                  (rst_n),
		.in_valid               (in_valid),
		.in_data                (in_data),
		.in_ready               (in_ready),
		.avl_waitrequest_n      (avl_waitrequest_n),
		.avl_write              (avl_write),
		.avl_address            (avl_address),
		.avl_writedata          (avl_writedata),
		.avl_burstcount         (avl_burstcount),
		.avl_beginbursttransfer (avl_beginbursttransfer)
	);

	always #5 avalon_clk = ~avalon_clk;   // 100 MHz

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model, lines packed lowest sample first, bursts in send order
	////////////////////////////////////////////////////////////////////////////

	function automatic line_t ref_line(input chan_t ch, input int burst, input int beat);
		line_t l;
		int    base;
		base = (burst * BURST_BEATS + beat) * WORDS_PER_LINE;
		for (int k = 0; k < WORDS_PER_LINE; k++) begin
			l[k*SAMPLE_W +: SAMPLE_W] = sent[ch][base + k];
		end
		return l;
	endfunction

	// channel in the top bits, line offset wraps at the region size
	function automatic dram_addr_t ref_addr(input chan_t ch, input int burst);
		logic [OFFS_W-1:0] offs;
		offs = OFFS_W'(burst * BURST_BEATS);
		return {ch, offs};
	endfunction

	// avalon slave, stalls at random only while random_wait is set
	always @(posedge avalon_clk) begin
		#1;
		wr_rng = xorshift32(wr_rng);
		avl_waitrequest_n = random_wait ? wr_rng[9] : 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// burst checker
	////////////////////////////////////////////////////////////////////////////

	always @(posedge avalon_clk) begin : compare
		chan_t ch;
		if (rst_n) begin
			if (held_valid) begin   // stalled beat stays on the bus unchanged
				assert (avl_write && avl_writedata == held_data && avl_address == held_addr)
				else begin
					$display("%s: beat withdrawn or changed while the slave held it", test_name);
					errors++;
				end
			end
			held_valid = avl_write && !avl_waitrequest_n;
			held_data  = avl_writedata;
			held_addr  = avl_address;
			if (avl_write && avl_waitrequest_n) begin   // beat taken
				if (beat_idx == 0) begin
					ch       = avl_address[ADDR_W-1 -: CH_W];
					cur_ch   = ch;
					cur_addr = avl_address;
					assert (avl_beginbursttransfer) else begin
						$display("%s: first beat without beginbursttransfer", test_name);
						errors++;
					end
					assert (sent_cnt[ch] >= (got[ch] + 1) * BURST_SAMPLES) else begin
						$display("%s: burst on channel %0d before its samples", test_name, ch);
						errors++;
					end
					assert (avl_address == ref_addr(ch, got[ch])) else begin
						$display("mismatch %s: address expected %h actual %h", test_name,
							ref_addr(ch, got[ch]), avl_address);
						errors++;
					end
				end else begin
					// a second begin or a new address means bursts interleaved
					assert (!avl_beginbursttransfer && avl_address == cur_addr) else begin
						$display("%s: burst interrupted at beat %0d", test_name, beat_idx);
						errors++;
					end
				end
				assert (avl_burstcount == burst_cnt_t'(BURST_BEATS)) else begin
					$display("mismatch %s: burstcount expected %0d actual %0d", test_name,
						BURST_BEATS, avl_burstcount);
					errors++;
				end
				assert (avl_writedata == ref_line(cur_ch, got[cur_ch], beat_idx)) else begin
					$display("mismatch %s: ch %0d beat %0d expected %h actual %h", test_name,
						cur_ch, beat_idx, ref_line(cur_ch, got[cur_ch], beat_idx),
						avl_writedata);
					errors++;
				end
				if (beat_idx == BURST_BEATS - 1) begin
					got[cur_ch]++;
					last_addr[cur_ch] = cur_addr;
					total_bursts++;
					beat_idx = 0;
				end else begin
					beat_idx++;
				end
			end
		end
	end

	// a full buffer must stall its channel until the burst drains
	always @(negedge avalon_clk) begin
		if (rst_n) begin
			for (int c = 0; c < NUM_CH; c++) begin
				if (sent_cnt[c] - got[c] * BURST_SAMPLES >= BURST_SAMPLES) begin
					assert (!in_ready[c]) else begin
						$display("%s: channel %0d ready with a full buffer", test_name, c);
						errors++;
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	// stream the given number of bursts on every channel of mask
	task automatic stream_bursts(input chan_mask_t mask, input int bursts);
		int left [NUM_CH];
		bit took [NUM_CH];
		int cyc;
		bit busy;
		for (int c = 0; c < NUM_CH; c++) begin
			left[c] = mask[c] ? bursts * BURST_SAMPLES : 0;
		end
		cyc  = 0;
		busy = 1'b1;
		while (busy && cyc < STREAM_TIMEOUT) begin
			@(posedge avalon_clk);
			for (int c = 0; c < NUM_CH; c++) begin
				took[c] = in_valid[c] && in_ready[c];
				if (took[c]) begin
					sent[c][sent_cnt[c]] = in_data[c];
					sent_cnt[c]++;
					left[c]--;
				end
			end
			#1;
			busy = 1'b0;
			for (int c = 0; c < NUM_CH; c++) begin
				if (left[c] > 0) begin
					if (!in_valid[c] || took[c]) begin   // hold data until accepted
						rng        = xorshift32(rng);
						in_data[c] = rng[15:0];
					end
					in_valid[c] = 1'b1;
					busy        = 1'b1;
				end else begin
					in_valid[c] = 1'b0;
				end
			end
			cyc++;
		end
		if (busy) begin
			$display("%s: timeout while streaming samples", test_name);
			errors++;
		end
	endtask

	task automatic wait_bursts(input int target);
		int cyc;
		cyc = 0;
		while (total_bursts < target && cyc < DRAIN_TIMEOUT) begin
			@(negedge avalon_clk);
			cyc++;
		end
		if (total_bursts < target) begin
			$display("%s: timeout, %0d of %0d bursts seen", test_name, total_bursts, target);
			errors++;
		end
	endtask

	// every sample sent must have come out in a whole burst
	task automatic check_drained();
		for (int c = 0; c < NUM_CH; c++) begin
			assert (got[c] * BURST_SAMPLES == sent_cnt[c]) else begin
				$display("mismatch %s: ch %0d bursts expected %0d actual %0d", test_name, c,
					sent_cnt[c] / BURST_SAMPLES, got[c]);
				errors++;
			end
		end
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic finish_test();
		if (errors == errors_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
			tests_failed++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rst_n             = 1'b0;
		in_valid          = '0;
		in_data           = '0;
		avl_waitrequest_n = 1'b1;
		random_wait       = 1'b0;
		rng               = SEED;
		wr_rng            = xorshift32(SEED);
		total_bursts      = 0;
		beat_idx          = 0;
		held_valid        = 1'b0;
		errors            = 0;
		tests_run         = 0;
		tests_failed      = 0;
		test_name         = "reset";
		for (int c = 0; c < NUM_CH; c++) begin
			sent_cnt[c]  = 0;
			got[c]       = 0;
			last_addr[c] = '0;
		end
		repeat (2) @(posedge avalon_clk);
		#1 rst_n = 1'b1;

		start_test("reset_state");
		@(negedge avalon_clk);
		assert (!avl_write && in_ready == '1) else begin
			$display("mismatch %s: expected write 0 ready ff actual write %b ready %h",
				test_name, avl_write, in_ready);
			errors++;
		end
		finish_test();

		start_test("single_channel");
		stream_bursts(8'b0000_1000, 1);
		wait_bursts(1);
		repeat (40) @(negedge avalon_clk);   // quiet window, no second burst
		assert (total_bursts == 1 && last_addr[3] == {3'd3, 22'd0}) else begin
			$display("mismatch %s: expected 1 burst at %h actual %0d at %h", test_name,
				{3'd3, 22'd0}, total_bursts, last_addr[3]);
			errors++;
		end
		finish_test();

		start_test("address_advance");
		stream_bursts(8'b0010_1000, 1);
		wait_bursts(3);
		assert (last_addr[3] == {3'd3, 22'd2} && last_addr[5] == {3'd5, 22'd0}) else begin
			$display("mismatch %s: expected %h %h actual %h %h", test_name, {3'd3, 22'd2},
				{3'd5, 22'd0}, last_addr[3], last_addr[5]);
			errors++;
		end
		check_drained();
		finish_test();

		start_test("all_channels");
		stream_bursts('1, 3);
		wait_bursts(3 + 3 * NUM_CH);
		check_drained();
		finish_test();

		start_test("back_pressure");
		random_wait = 1'b1;
		stream_bursts('1, 2);
		wait_bursts(3 + 5 * NUM_CH);
		random_wait = 1'b0;
		check_drained();
		finish_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
hw/capture_pkg.sv
hw/lane_packer.sv
hw/burst_arbiter.sv
hw/dram_write_ctrl.sv
hw/capture_top.sv
test/tb_capture_top.sv

// ==== Bender.yml ====
package:
  name: capture

sources:
  - hw/capture_pkg.sv
  - hw/lane_packer.sv
  - hw/burst_arbiter.sv
  - hw/dram_write_ctrl.sv
  - hw/capture_top.sv
  - target: test
    files:
      - test/tb_capture_top.sv
